// ==== Bender.yml ====
package:
  name: net_tx

dependencies: {}

sources:
  - design/net_tx_pkg.sv
  - design/ip_checksum.sv
  - design/udp_tx.sv
  - design/ip_tx.sv
  - design/eth_tx.sv
  - design/net_tx_top.sv
  - target: simulation
    files:
      - dv/net_tx_tb.sv

// ==== design/eth_tx.sv ====
//----------------------------------------------------------
// Ethernet II header inserter, MACs and IPv4 type
//----------------------------------------------------------
`timescale 1ns/1ps

module eth_tx
	import net_tx_pkg::*;
(
	input  logic      s_axis_aclk,
	input  logic      rst_n,
	input  logic      s_valid,
	input  beat_t     s_beat,
	output logic      s_ready,
	output logic      m_valid,
	output beat_t     m_beat,
	input  logic      m_ready,
	input  mac_addr_t src_mac,
	input  mac_addr_t dest_mac
);

	hdr_state_t state;
	eth_idx_t   cnt;
	logic       frame_start;
	mac_addr_t  src_mac_q;
	mac_addr_t  dest_mac_q;
	byte_t [0:ETH_HDR_LEN-1] hdr;

	assign frame_start = (state == IDLE) && s_valid && s_beat.user;

	// Destination first on the wire
	assign hdr = {dest_mac_q, src_mac_q, ETH_TYPE_IPV4};

	always_ff @(posedge s_axis_aclk)
	begin
		if (frame_start)
		begin
			src_mac_q  <= src_mac;
			dest_mac_q <= dest_mac;
		end
	end

	always_ff @(posedge s_axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (frame_start)
						state <= HEADER;
				end
				HEADER:
				begin
					if (m_ready)
					begin
						if (cnt == eth_idx_t'(ETH_HDR_LEN - 1))
						begin
							cnt   <= '0;
							state <= PAYLOAD;
						end
						else
							cnt <= cnt + 1'b1;
					end
				end
				PAYLOAD:
				begin
					if (s_valid && m_ready && s_beat.last)
						state <= IDLE;	// Frame done, wait for next user
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_comb
	begin
		m_valid = 1'b0;
		s_ready = 1'b0;
		m_beat  = '{data: hdr[cnt], last: 1'b0, user: (cnt == '0)};
		case (state)
			IDLE:
				s_ready = ~s_beat.user;
			HEADER:
				m_valid = 1'b1;
			PAYLOAD:
			begin
				m_valid = s_valid;
				s_ready = m_ready;
				m_beat  = '{data: s_beat.data, last: s_beat.last, user: 1'b0};
			end
			default:
				s_ready = 1'b0;
		endcase
	end

endmodule

// ==== design/ip_checksum.sv ====
//----------------------------------------------------------
// IPv4 header checksum, ones-complement fold, registered
//----------------------------------------------------------
`timescale 1ns/1ps

module ip_checksum
	import net_tx_pkg::*;
(
	input  logic        s_axis_aclk,
	input  logic        rst_n,
	input  len_t        total_len,
	input  ip_addr_t    src_ip,
	input  ip_addr_t    dest_ip,
	output logic [15:0] checksum
);

	logic [19:0] sum;	// Nine 16-bit words fit in 20 bits
	logic [16:0] fold_1;
	logic [15:0] fold_2;

	always_comb
	begin
		sum = 20'({IP_VERSION, IP_IHL, IP_TOS}) + 20'(total_len) + 20'(IP_ID)
			+ 20'({IP_FLAGS, IP_FRAG_OFF}) + 20'({IP_TTL, IP_PROTO_UDP})
			+ 20'(src_ip[31:16]) + 20'(src_ip[15:0])
			+ 20'(dest_ip[31:16]) + 20'(dest_ip[15:0]);
		fold_1 = 17'(sum[15:0]) + 17'(sum[19:16]);
		// Second fold cannot carry again
		fold_2 = fold_1[15:0] + 16'(fold_1[16]);
	end

	always_ff @(posedge s_axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
			checksum <= '0;
		else
			checksum <= ~fold_2;
	end

endmodule

// ==== design/ip_tx.sv ====
//----------------------------------------------------------
// IPv4 header inserter with computed header checksum
//----------------------------------------------------------
`timescale 1ns/1ps

module ip_tx
	import net_tx_pkg::*;
(
	input  logic     s_axis_aclk,
	input  logic     rst_n,
	input  logic     s_valid,
	input  beat_t    s_beat,
	output logic     s_ready,
	output logic     m_valid,
	output beat_t    m_beat,
	input  logic     m_ready,
	input  ip_addr_t src_ip,
	input  ip_addr_t dest_ip,
	input  len_t     payload_len
);

	hdr_state_t  state;
	ip_idx_t     cnt;
	logic        frame_start;
	len_t        total_len_q;
	ip_addr_t    src_ip_q;
	ip_addr_t    dest_ip_q;
	logic [15:0] checksum;
	byte_t [0:IP_HDR_LEN-1] hdr;

	assign frame_start = (state == IDLE) && s_valid && s_beat.user;

	// Sample the frame fields while the user beat is held
	always_ff @(posedge s_axis_aclk)
	begin
		if (frame_start)
		begin
			total_len_q <= payload_len + len_t'(IP_HDR_LEN + UDP_HDR_LEN);
			src_ip_q    <= src_ip;
			dest_ip_q   <= dest_ip;
		end
	end

	// Settles one cycle after the sample, long before byte 10
	ip_checksum u_ip_checksum (
		.s_axis_aclk (s_axis_aclk),
		.rst_n       (rst_n),
		.total_len   (total_len_q),
		.src_ip      (src_ip_q),
		.dest_ip     (dest_ip_q),
		.checksum    (checksum)
	);

	assign hdr = {IP_VERSION, IP_IHL, IP_TOS, total_len_q, IP_ID,
		IP_FLAGS, IP_FRAG_OFF, IP_TTL, IP_PROTO_UDP, checksum,
		src_ip_q, dest_ip_q};

	always_ff @(posedge s_axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (frame_start)
						state <= HEADER;
				end
				HEADER:
				begin
					if (m_ready)
					begin
						if (cnt == ip_idx_t'(IP_HDR_LEN - 1))
						begin
							cnt   <= '0;
							state <= PAYLOAD;
						end
						else
							cnt <= cnt + 1'b1;
					end
				end
				PAYLOAD:
				begin
					// UDP segment passes through up to its last byte
					if (s_valid && m_ready && s_beat.last)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_comb
	begin
		m_valid = 1'b0;
		s_ready = 1'b0;
		m_beat  = '{data: hdr[cnt], last: 1'b0, user: (cnt == '0)};
		case (state)
			IDLE:
				s_ready = ~s_beat.user;
			HEADER:
				m_valid = 1'b1;	// Input beat stays held
			PAYLOAD:
			begin
				m_valid = s_valid;
				s_ready = m_ready;
				m_beat  = '{data: s_beat.data, last: s_beat.last, user: 1'b0};
			end
			default:
				s_ready = 1'b0;
		endcase
	end

endmodule

// ==== design/net_tx_pkg.sv ====
//----------------------------------------------------------
// Shared types, header constants, stream beat and config
// structs and the inserter state enum for the UDP/IP/Eth chain
//----------------------------------------------------------
package net_tx_pkg;

	// Plain widths
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] len_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] port_t;

	// Header lengths in bytes
	localparam int UDP_HDR_LEN = 8;
	localparam int IP_HDR_LEN  = 20;
	localparam int ETH_HDR_LEN = 14;

	// Byte counter widths of the three inserters
	typedef logic [$clog2(UDP_HDR_LEN)-1:0] udp_idx_t;
	typedef logic [$clog2(IP_HDR_LEN)-1:0]  ip_idx_t;
	typedef logic [$clog2(ETH_HDR_LEN)-1:0] eth_idx_t;

	// Fixed IPv4 header fields
	localparam logic [3:0]  IP_VERSION   = 4'd4;
	localparam logic [3:0]  IP_IHL       = 4'd5;	// No options
	localparam byte_t       IP_TOS       = 8'd0;
	localparam logic [15:0] IP_ID        = 16'd0;
	localparam logic [2:0]  IP_FLAGS     = 3'd2;	// Don't fragment
	localparam logic [12:0] IP_FRAG_OFF  = 13'd0;
	localparam byte_t       IP_TTL       = 8'd64;
	localparam byte_t       IP_PROTO_UDP = 8'd17;

	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

	// One byte of the stream, valid and ready travel beside it
	typedef struct packed {
		byte_t data;
		logic  last;	// Final byte of the frame
		logic  user;	// First byte of the frame
	} beat_t;

	// Per-frame addressing for all three layers
	typedef struct packed {
		mac_addr_t src_mac;
		mac_addr_t dest_mac;
		ip_addr_t  src_ip;
		ip_addr_t  dest_ip;
		port_t     src_port;
		port_t     dest_port;
		len_t      payload_len;	// UDP payload bytes
	} net_cfg_t;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PAYLOAD
	} hdr_state_t;

endpackage

// ==== design/net_tx_top.sv ====
//----------------------------------------------------------
// Transmit header chain, UDP then IPv4 then Ethernet II
//----------------------------------------------------------
`timescale 1ns/1ps

module net_tx_top
	import net_tx_pkg::*;
(
	input  logic     s_axis_aclk,
	input  logic     rst_n,
	input  net_cfg_t cfg,
	input  logic     s_valid,
	input  beat_t    s_beat,
	output logic     s_ready,
	output logic     m_valid,
	output beat_t    m_beat,
	input  logic     m_ready
);

	// UDP segment into the IP layer
	logic  udp_valid;
	beat_t udp_beat;
	logic  udp_ready;

	// IP packet into the Ethernet layer
	logic  ip_valid;
	beat_t ip_beat;
	logic  ip_ready;

	udp_tx u_udp_tx (
		.s_axis_aclk (s_axis_aclk),
		.rst_n       (rst_n),
		.s_valid     (s_valid),
		.s_beat      (s_beat),
		.s_ready     (s_ready),
		.m_valid     (udp_valid),
		.m_beat      (udp_beat),
		.m_ready     (udp_ready),
		.src_port    (cfg.src_port),
		.dest_port   (cfg.dest_port),
		.payload_len (cfg.payload_len)
	);

	ip_tx u_ip_tx (
		.s_axis_aclk (s_axis_aclk),
		.rst_n       (rst_n),
		.s_valid     (udp_valid),
		.s_beat      (udp_beat),
		.s_ready     (udp_ready),
		.m_valid     (ip_valid),
		.m_beat      (ip_beat),
		.m_ready     (ip_ready),
		.src_ip      (cfg.src_ip),
		.dest_ip     (cfg.dest_ip),
		.payload_len (cfg.payload_len)	// Adds both header lengths itself
	);

	eth_tx u_eth_tx (
		.s_axis_aclk (s_axis_aclk),
		.rst_n       (rst_n),
		.s_valid     (ip_valid),
		.s_beat      (ip_beat),
		.s_ready     (ip_ready),
		.m_valid     (m_valid),
		.m_beat      (m_beat),
		.m_ready     (m_ready),
		.src_mac     (cfg.src_mac),
		.dest_mac    (cfg.dest_mac)
	);

endmodule

// ==== design/udp_tx.sv ====
//----------------------------------------------------------
// UDP header inserter, ports and length ahead of the payload
//----------------------------------------------------------
`timescale 1ns/1ps

module udp_tx
	import net_tx_pkg::*;
(
	input  logic  s_axis_aclk,
	input  logic  rst_n,
	input  logic  s_valid,
	input  beat_t s_beat,
	output logic  s_ready,
	output logic  m_valid,
	output beat_t m_beat,
	input  logic  m_ready,
	input  port_t src_port,
	input  port_t dest_port,
	input  len_t  payload_len
);

	hdr_state_t state;
	udp_idx_t   cnt;
	logic       frame_start;
	port_t      src_port_q;
	port_t      dest_port_q;
	len_t       udp_len_q;
	byte_t [0:UDP_HDR_LEN-1] hdr;	// Index 0 goes out first

	assign frame_start = (state == IDLE) && s_valid && s_beat.user;

	// Checksum left at zero, allowed over IPv4
	assign hdr = {src_port_q, dest_port_q, udp_len_q, 16'h0000};

	always_ff @(posedge s_axis_aclk)
	begin
		if (frame_start)
		begin
			src_port_q  <= src_port;
			dest_port_q <= dest_port;
			udp_len_q   <= payload_len + len_t'(UDP_HDR_LEN);
		end
	end

	always_ff @(posedge s_axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (frame_start)
						state <= HEADER;
				end
				HEADER:
				begin
					if (m_ready)	// Counter only moves on a transfer
					begin
						if (cnt == udp_idx_t'(UDP_HDR_LEN - 1))
						begin
							cnt   <= '0;
							state <= PAYLOAD;
						end
						else
							cnt <= cnt + 1'b1;
					end
				end
				PAYLOAD:
				begin
					if (s_valid && m_ready && s_beat.last)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_comb
	begin
		m_valid = 1'b0;
		s_ready = 1'b0;
		m_beat  = '{data: hdr[cnt], last: 1'b0, user: (cnt == '0)};
		case (state)
			IDLE:
				s_ready = ~s_beat.user;	// Stray beats are dropped
			HEADER:
				m_valid = 1'b1;
			PAYLOAD:
			begin
				m_valid = s_valid;
				s_ready = m_ready;
				m_beat  = '{data: s_beat.data, last: s_beat.last, user: 1'b0};
			end
			default:
				s_ready = 1'b0;
		endcase
	end

endmodule

// ==== dv/net_tx_tb.sv ====
//----------------------------------------------------------
// Directed testbench for the UDP/IPv4/Ethernet header chain
// with reference header model, compare tasks and timeout
//----------------------------------------------------------
`timescale 1ns/1ps

module net_tx_tb
	import net_tx_pkg::*;
();

	localparam int MAX_PAYLOAD = 32;
	localparam int NUM_FRAMES  = 16;
	// Every frame at full length with the output stalled up to 4x
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_PAYLOAD + 42) * 4 + 500;

	logic     s_axis_aclk;
	logic     rst_n;
	net_cfg_t cfg;
	logic     s_valid;
	beat_t    s_beat;
	logic     s_ready;
	logic     m_valid;
	beat_t    m_beat;
	logic     m_ready;

	integer seed     = 703;
	int     errors   = 0;
	int     checks   = 0;
	int     cycles   = 0;
	logic   stall_en = 1'b0;
	beat_t  exp_q[$];	// Expected output beats in order
	byte_t  rx_q[$];
	byte_t  frame_q[$];

	net_tx_top UUT (.*);

	initial
	begin
		s_axis_aclk = 1'b0;
		forever #2 s_axis_aclk = ~s_axis_aclk;
	end

	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge s_axis_aclk);
			cycles++;
		end
		$display("Timeout after %0d cycles, output stream never completed", cycles);
		$display("Test failures found");
		$finish;
	end

	// Output back-pressure
	always @(posedge s_axis_aclk)
	begin
		#1;
		if (stall_en)
			m_ready = $random(seed);
		else
			m_ready = 1'b1;
	end

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_len(input string name, input len_t got, input len_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Beat is stable at the falling edge before the rising edge that takes it
	always @(negedge s_axis_aclk)
	begin
		if (m_valid && m_ready)
		begin
			rx_q.push_back(m_beat.data);
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Output byte 0x%h appeared while no frame was expected", m_beat.data);
			end
			else
			begin
				check_byte("m_beat.data", m_beat.data, exp_q[0].data);
				check_flag("m_beat.user", m_beat.user, exp_q[0].user);
				check_flag("m_beat.last", m_beat.last, exp_q[0].last);
				void'(exp_q.pop_front());
			end
		end
	end

	// Ones-complement sum of the ten header words with the checksum word as zero
	function automatic logic [15:0] ref_checksum(input len_t total, input ip_addr_t src,
		input ip_addr_t dst);
		logic [31:0] sum;
		sum = 32'h4500 + total + 32'h0000 + 32'h4000 + 32'h4011
			+ src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
		while (sum[31:16] != 0)
			sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	function automatic net_cfg_t rand_cfg(input int len);
		net_cfg_t c;
		c.src_mac     = {$random(seed), $random(seed)};
		c.dest_mac    = {$random(seed), $random(seed)};
		c.src_ip      = $random(seed);
		c.dest_ip     = $random(seed);
		c.src_port    = $random(seed);
		c.dest_port   = $random(seed);
		c.payload_len = len_t'(len);
		return c;
	endfunction

	task automatic push_field(input logic [47:0] val, input int nbytes);
		for (int i = nbytes - 1; i >= 0; i--)
			frame_q.push_back(val[8*i +: 8]);
	endtask

	// Expected frame as Ethernet, IPv4 and UDP headers followed by the payload
	task automatic build_expected(input net_cfg_t c, input byte_t first);
		len_t ip_len;
		len_t udp_len;
		ip_len  = c.payload_len + 16'd28;
		udp_len = c.payload_len + 16'd8;
		frame_q.delete();
		push_field(c.dest_mac, 6);
		push_field(c.src_mac, 6);
		push_field(48'h0800, 2);
		push_field(48'h4500, 2);
		push_field(ip_len, 2);
		push_field(48'h0000_4000, 4);	// ID zero then DF with zero offset
		push_field(48'h4011, 2);	// TTL 64 and protocol UDP
		push_field(ref_checksum(ip_len, c.src_ip, c.dest_ip), 2);
		push_field(c.src_ip, 4);
		push_field(c.dest_ip, 4);
		push_field(c.src_port, 2);
		push_field(c.dest_port, 2);
		push_field(udp_len, 2);
		push_field(48'h0, 2);
		for (int i = 0; i < c.payload_len; i++)
			frame_q.push_back(first + byte_t'(3 * i));
		foreach (frame_q[i])
			exp_q.push_back('{data: frame_q[i], last: (i == frame_q.size() - 1), user: (i == 0)});
	endtask

	task automatic wait_taken();
		logic took;
		took = 1'b0;
		while (!took)
		begin
			@(negedge s_axis_aclk);
			took = s_valid && s_ready;
			@(posedge s_axis_aclk);
			#1;
		end
	endtask

	task automatic send_frame(input net_cfg_t c, input byte_t first);
		build_expected(c, first);
		cfg = c;	// Whole chain is idle again by now
		for (int i = 0; i < c.payload_len; i++)
		begin
			s_valid = 1'b1;
			s_beat  = '{data: first + byte_t'(3 * i), last: (i == c.payload_len - 1),
				user: (i == 0)};
			wait_taken();
		end
	endtask

	// Stop driving and wait until every expected byte has left the DUT
	task automatic drain();
		s_valid = 1'b0;
		s_beat  = '0;
		while (exp_q.size() != 0)
		begin
			@(posedge s_axis_aclk);
			#1;
		end
	endtask

	task automatic report(input string name, input int start);
		$display("%-20s %0d errors", name, errors - start);
	endtask

	task automatic single_frame();
		int start;
		start = errors;
		rx_q.delete();
		send_frame(rand_cfg(6), 8'h10);
		drain();
		check_len("output byte count", len_t'(rx_q.size()), 16'd48);
		report("single frame", start);
	endtask

	task automatic checksum_and_lengths();
		int start;
		net_cfg_t c;
		logic [15:0] ck;
		start = errors;
		repeat (8)
		begin
			c = rand_cfg(1 + $unsigned($random(seed)) % MAX_PAYLOAD);
			rx_q.delete();
			send_frame(c, $random(seed));
			drain();
			check_len("output byte count", len_t'(rx_q.size()), c.payload_len + 16'd42);
			if (rx_q.size() >= 42)
			begin
				ck = ref_checksum(c.payload_len + 16'd28, c.src_ip, c.dest_ip);
				check_len("ip total_len", {rx_q[16], rx_q[17]}, c.payload_len + 16'd28);
				check_len("udp length", {rx_q[38], rx_q[39]}, c.payload_len + 16'd8);
				check_byte("ip checksum[15:8]", rx_q[24], ck[15:8]);
				check_byte("ip checksum[7:0]", rx_q[25], ck[7:0]);
			end
		end
		report("checksum and length", start);
	endtask

	task automatic output_backpressure();
		int start;
		net_cfg_t c1;
		net_cfg_t c2;
		byte_t ref_rx[$];
		start = errors;
		c1 = rand_cfg(20);
		c2 = rand_cfg(5);
		rx_q.delete();
		stall_en = 1'b1;
		send_frame(c1, 8'h21);
		ref_rx = frame_q;	// Reference bytes of the first frame
		send_frame(c2, 8'h77);
		foreach (frame_q[i])
			ref_rx.push_back(frame_q[i]);
		drain();
		stall_en = 1'b0;
		check_len("stalled byte count", len_t'(rx_q.size()), len_t'(ref_rx.size()));
		foreach (ref_rx[i])
			if (i < rx_q.size())
				check_byte("stalled m_beat.data", rx_q[i], ref_rx[i]);
		report("back-pressure", start);
	endtask

	task automatic back_to_back_frames();
		int start;
		start = errors;
		rx_q.delete();
		send_frame(rand_cfg(9), 8'h30);
		send_frame(rand_cfg(2), 8'h50);
		send_frame(rand_cfg(14), 8'h90);
		drain();
		check_len("output byte count", len_t'(rx_q.size()), 16'd151);
		report("back-to-back", start);
	endtask

	task automatic stray_beats();
		int start;
		start = errors;
		rx_q.delete();
		for (int i = 0; i < 3; i++)
		begin
			s_valid = 1'b1;
			s_beat  = '{data: 8'hA0 + byte_t'(i), last: (i == 2), user: 1'b0};
			wait_taken();
		end
		s_valid = 1'b0;
		repeat (10) @(posedge s_axis_aclk);	// Any stray output shows up here
		#1;
		send_frame(rand_cfg(4), 8'h40);
		drain();
		check_len("output byte count", len_t'(rx_q.size()), 16'd46);
		report("stray beats", start);
	endtask

	task automatic one_byte_payload();
		int start;
		start = errors;
		rx_q.delete();
		send_frame(rand_cfg(1), 8'h5A);
		drain();
		check_len("output byte count", len_t'(rx_q.size()), 16'd43);
		report("one-byte payload", start);
	endtask

	initial
	begin
		rst_n   = 1'b0;
		cfg     = '0;
		s_valid = 1'b0;
		s_beat  = '0;
		m_ready = 1'b1;
		repeat (4) @(posedge s_axis_aclk);
		#1;
		rst_n = 1'b1;
		single_frame();
		checksum_and_lengths();
		output_backpressure();
		back_to_back_frames();
		stray_beats();
		one_byte_payload();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== net_tx_top.f ====
design/net_tx_pkg.sv
design/ip_checksum.sv
design/udp_tx.sv
design/ip_tx.sv
design/eth_tx.sv
design/net_tx_top.sv
dv/net_tx_tb.sv
